/* Bender.yml */
package:
  name: enemy_subsystem

sources:
  - hw/enemyPkg.sv
  - hw/keyDecoder.sv
  - hw/enemyTimers.sv
  - hw/enemyMotionFsm.sv
  - hw/spriteAddressGen.sv
  - hw/enemySubsystem.sv
  - target: test
    files:
      - tests/enemyTb.sv

/* flist.f */
hw/enemyPkg.sv
hw/keyDecoder.sv
hw/enemyTimers.sv
hw/enemyMotionFsm.sv
hw/spriteAddressGen.sv
hw/enemySubsystem.sv
tests/enemyTb.sv

/* hw/enemyMotionFsm.sv */
// Moves at most once per frameTick; spawn must be a constant and the reset position derives from it
module enemyMotionFsm (
    input  logic               Clk,
    input  logic               arstN,
    input  logic               frameTick,
    input  logic               attacked,
    input  logic               isAlive,
    input  enemyPkg::keyStateT keys,
    input  logic               stunned,
    input  enemyPkg::posT      player,
    input  enemyPkg::posT      spawn,
    output enemyPkg::posT      enemyPos,
    output enemyPkg::dirT      facing,
    output logic               moving,
    output logic               attackReady
);
    import enemyPkg::*;

    typedef enum logic [1:0] {
        sChase,
        sPossessed,
        sKnock,
        sStay
    } stateT;

    stateT             state;
    stateT             mode;
    dirT               reqDir;
    dirT               newFacing;
    logic [coordW-1:0] stepSize;
    logic              wantMove;
    logic              canStep;
    logic              stepTaken;
    logic              readyNext;
    logic              grownOverlap;
    logic              goRight;
    logic              goLeft;
    logic              goDown;
    logic              goUp;
    posT               stepPos;
    posT               resetPos;

    // Sprite is centred on the spawn point
    assign resetPos = '{x: spawn.x - coordW'(spriteW / 2), y: spawn.y - coordW'(spriteH / 2)};

    // Chase compares against the player box, possession uses held keys
    assign goRight = keys.possessed ? keys.right : (enemyPos.x + spriteW < player.x);
    assign goLeft  = keys.possessed ? keys.left  : (enemyPos.x > player.x + playerW);
    assign goDown  = keys.possessed ? keys.down  : (enemyPos.y + spriteH < player.y);
    assign goUp    = keys.possessed ? keys.up    : (enemyPos.y > player.y + playerH);

    // Both boxes grown by the attack reach
    assign grownOverlap = (enemyPos.x + spriteW + attackDist >= player.x)
                       && (enemyPos.x <= player.x + playerW + attackDist)
                       && (enemyPos.y + spriteH + attackDist >= player.y)
                       && (enemyPos.y <= player.y + playerH + attackDist);

    // Pick this frame's move, hit first, then stun, then walking rule
    always_comb begin
        mode     = keys.possessed ? sPossessed : sChase;
        reqDir   = facing;
        stepSize = coordW'(walkStep);
        wantMove = 1'b1;
        if (attacked) begin
            mode     = sKnock;
            reqDir   = dirT'(facing ^ 2'd2); // Back away from where we face
            stepSize = coordW'(knockStep);
        end else if (stunned) begin
            mode     = sStay;
            wantMove = 1'b0;
        end else if (goRight) begin
            reqDir = dirRight;
        end else if (goLeft) begin
            reqDir = dirLeft;
        end else if (goDown) begin
            reqDir = dirDown;
        end else if (goUp) begin
            reqDir = dirUp;
        end else begin
            wantMove = 1'b0; // Lined up with the player
        end
    end

    // Arena check for the requested step
    always_comb begin
        stepPos = enemyPos;
        unique case (reqDir)
            dirRight: begin
                canStep   = (enemyPos.x + spriteW + stepSize <= xMax);
                stepPos.x = enemyPos.x + stepSize;
            end
            dirLeft: begin
                canStep   = (enemyPos.x >= xMin + stepSize);
                stepPos.x = enemyPos.x - stepSize;
            end
            dirDown: begin
                canStep   = (enemyPos.y + spriteH + stepSize <= yMax);
                stepPos.y = enemyPos.y + stepSize;
            end
            default: begin
                canStep   = (enemyPos.y >= yMin + stepSize);
                stepPos.y = enemyPos.y - stepSize;
            end
        endcase
    end

    assign stepTaken = wantMove && canStep;
    assign moving    = frameTick && isAlive && stepTaken;
    assign newFacing = (wantMove && !attacked) ? reqDir : facing; // Turns even when blocked

    assign readyNext = keys.possessed ? grownOverlap : (!stepTaken && !attacked && !stunned);

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            state       <= sChase;
            enemyPos    <= resetPos;
            facing      <= dirDown;
            attackReady <= 1'b0;
        end else begin
            if (frameTick) begin
                state <= mode;
            end
            if (!isAlive) begin
                attackReady <= 1'b0; // Dead enemy is frozen in place
            end else if (frameTick) begin
                if (stepTaken) begin
                    enemyPos <= stepPos;
                end
                facing      <= newFacing;
                attackReady <= readyNext;
            end
        end
    end

    // The timer block must start its stay count on the knockback tick
    assert property (@(posedge Clk) disable iff (!arstN) state == sKnock |-> stunned)
        else $error("Knockback without a running stay count");

    // Vertical limits hold from reset on
    assert property (@(posedge Clk) disable iff (!arstN)
        enemyPos.y >= yMin && enemyPos.y + spriteH <= yMax)
        else $error("Enemy left the arena vertically");

    // Left spawn slots start wrapped below x = 0, so only rightward steps are bounded
    assert property (@(posedge Clk) disable iff (!arstN)
        enemyPos.x > $past(enemyPos.x) |-> enemyPos.x + spriteW <= xMax)
        else $error("Enemy stepped past the right arena edge");

endmodule

/* hw/enemyPkg.sv */
// Shared enemy constants and types; coordinates are unsigned 9-bit screen pixels, top-left origin
package enemyPkg;

    // Screen geometry
    localparam int coordW = 9;
    localparam int spriteW = 26;
    localparam int spriteH = 26;
    localparam int playerW = 18;
    localparam int playerH = 20;
    localparam int attackDist = 3; // Reach added on every side of both boxes

    // Arena limits for the enemy box
    localparam int xMin = 0;
    localparam int xMax = 319;
    localparam int yMin = 52;
    localparam int yMax = 205;

    // Motion per frame
    localparam int walkStep = 1;
    localparam int knockStep = 3;

    // Frames spent standing still after a hit
    localparam int stayFrames = 6;
    localparam int stayCntW = $clog2(stayFrames + 1);

    // USB HID scan codes
    localparam logic [7:0] keyW = 8'd26;
    localparam logic [7:0] keyA = 8'd4;
    localparam logic [7:0] keyS = 8'd22;
    localparam logic [7:0] keyD = 8'd7;
    localparam logic [7:0] keyG = 8'd10; // Possession toggle

    localparam int romAddrW = 14;

    // Spawn centres, one per slot, clockwise from the top-left corner
    localparam logic [coordW-1:0] spawnX [4] = '{9'd5, 9'd315, 9'd315, 9'd5};
    localparam logic [coordW-1:0] spawnY [4] = '{9'd65, 9'd65, 9'd180, 9'd180};

    // Facing, also the upper bits of the sprite frame number
    typedef enum logic [1:0] {
        dirDown  = 2'd0,
        dirLeft  = 2'd1,
        dirUp    = 2'd2,
        dirRight = 2'd3
    } dirT;

    typedef struct packed {
        logic [coordW-1:0] x;
        logic [coordW-1:0] y;
    } posT;

    typedef struct packed {
        logic up;
        logic left;
        logic down;
        logic right;
        logic possessed;
    } keyStateT;

    typedef struct packed {
        logic [1:0] step;    // Walk animation phase
        logic       stunned; // Stay counter running
    } animT;

endpackage

/* hw/enemySubsystem.sv */
// One enemy per instance; spawnSlot must be 0..3 and only slot 0 can be possessed by the keyboard
module enemySubsystem #(
    parameter int spawnSlot = 0
) (
    input  logic                          Clk,
    input  logic                          arstN,
    input  logic                          frameTick,
    input  logic [15:0]                   keycode,
    input  enemyPkg::posT                 player,
    input  enemyPkg::posT                 pixel,
    input  logic                          attacked,
    input  logic                          isAlive,
    output logic                          isObj,
    output logic [enemyPkg::romAddrW-1:0] romAddr,
    output enemyPkg::posT                 enemyPos,
    output enemyPkg::dirT                 facing,
    output logic                          attackReady,
    output logic                          possessed
);
    import enemyPkg::*;

    keyStateT keys;
    animT     anim;
    posT      spawn;
    logic     moving;
    logic     possessEn;

    assign spawn     = '{x: spawnX[spawnSlot], y: spawnY[spawnSlot]};
    assign possessEn = (spawnSlot == 0);
    assign possessed = keys.possessed;

    keyDecoder uKeys (
        .Clk       (Clk),
        .arstN     (arstN),
        .frameTick (frameTick),
        .keycode   (keycode),
        .possessEn (possessEn),
        .keys      (keys)
    );

    enemyTimers uTimers (
        .Clk       (Clk),
        .arstN     (arstN),
        .frameTick (frameTick),
        .attacked  (attacked),
        .moving    (moving),
        .anim      (anim)
    );

    enemyMotionFsm uMotion (
        .Clk         (Clk),
        .arstN       (arstN),
        .frameTick   (frameTick),
        .attacked    (attacked),
        .isAlive     (isAlive),
        .keys        (keys),
        .stunned     (anim.stunned),
        .player      (player),
        .spawn       (spawn),
        .enemyPos    (enemyPos),
        .facing      (facing),
        .moving      (moving),
        .attackReady (attackReady)
    );

    spriteAddressGen uSprite (
        .enemyPos (enemyPos),
        .pixel    (pixel),
        .facing   (facing),
        .anim     (anim),
        .isAlive  (isAlive),
        .isObj    (isObj),
        .romAddr  (romAddr)
    );

endmodule

/* hw/enemyTimers.sv */
// Both counters advance only on frameTick; attacked is meaningful only in a tick cycle
module enemyTimers (
    input  logic           Clk,
    input  logic           arstN,
    input  logic           frameTick,
    input  logic           attacked,
    input  logic           moving,
    output enemyPkg::animT anim
);
    import enemyPkg::*;

    logic [stayCntW-1:0] stayCnt;
    logic [1:0]          stepCnt;

    // Stay counter runs 1..stayFrames after a hit, idle at zero
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            stayCnt <= '0;
        end else if (frameTick) begin
            if (attacked) begin
                stayCnt <= stayCntW'(1); // A new hit restarts the wait
            end else if (stayCnt == stayCntW'(stayFrames)) begin
                stayCnt <= '0;
            end else if (stayCnt != '0) begin
                stayCnt <= stayCnt + stayCntW'(1);
            end
        end
    end

    // Walk phase, wraps through four poses
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            stepCnt <= '0;
        end else if (frameTick && moving) begin
            stepCnt <= stepCnt + 2'd1;
        end
    end

    assign anim.stunned = (stayCnt != '0);
    assign anim.step    = stepCnt;

    assert property (@(posedge Clk) disable iff (!arstN)
        stayCnt <= stayCntW'(stayFrames))
        else $error("Stay counter ran past its limit");

endmodule

/* hw/keyDecoder.sv */
// Keycode holds two independent scan code bytes; possession only toggles when possessEn is set
module keyDecoder (
    input  logic               Clk,
    input  logic               arstN,
    input  logic               frameTick,
    input  logic [15:0]        keycode,
    input  logic               possessEn,
    output enemyPkg::keyStateT keys
);
    import enemyPkg::*;

    logic possessedQ;
    logic gHeld;

    // True when either byte carries the given scan code
    function automatic logic hasKey(input logic [15:0] code, input logic [7:0] key);
        return (code[7:0] == key) || (code[15:8] == key);
    endfunction

    assign gHeld = hasKey(keycode, keyG);

    // One toggle per frame while G is down
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            possessedQ <= 1'b0;
        end else if (frameTick && gHeld && possessEn) begin
            possessedQ <= ~possessedQ;
        end
    end

    assign keys.up        = hasKey(keycode, keyW);
    assign keys.left      = hasKey(keycode, keyA);
    assign keys.down      = hasKey(keycode, keyS);
    assign keys.right     = hasKey(keycode, keyD);
    assign keys.possessed = possessedQ;

endmodule

/* hw/spriteAddressGen.sv */
// Purely combinational; ROM holds 16 frames of 26x26 words, four poses per facing
module spriteAddressGen (
    input  enemyPkg::posT               enemyPos,
    input  enemyPkg::posT               pixel,
    input  enemyPkg::dirT               facing,
    input  enemyPkg::animT              anim,
    input  logic                        isAlive,
    output logic                        isObj,
    output logic [enemyPkg::romAddrW-1:0] romAddr
);
    import enemyPkg::*;

    logic [coordW-1:0]   dx;
    logic [coordW-1:0]   dy;
    logic                inBox;
    logic [1:0]          pose;
    logic [3:0]          frameNum;
    logic [romAddrW-1:0] frameBase;
    logic [romAddrW-1:0] rowBase;

    assign dx = pixel.x - enemyPos.x;
    assign dy = pixel.y - enemyPos.y;

    assign inBox = (pixel.x >= enemyPos.x) && (pixel.x < enemyPos.x + spriteW)
                && (pixel.y >= enemyPos.y) && (pixel.y < enemyPos.y + spriteH);

    assign isObj = inBox && isAlive;

    // Stunned pose, else standing on even steps and alternating feet on odd ones
    always_comb begin
        if (anim.stunned) begin
            pose = 2'd3;
        end else if (anim.step[0]) begin
            pose = 2'd1 + {1'b0, anim.step[1]};
        end else begin
            pose = 2'd0;
        end
    end

    assign frameNum  = {facing, pose}; // 4 * facing + pose
    assign frameBase = romAddrW'(frameNum * (spriteW * spriteH));
    assign rowBase   = romAddrW'(dy * spriteW);

    assign romAddr = isObj ? frameBase + rowBase + romAddrW'(dx) : '0;

endmodule

/* tests/enemyTb.sv */
// Single enemy in spawn slot 0, fixed-seed LFSR stimulus; the first mismatch ends the run
module enemyTb;
    import enemyPkg::*;

    localparam int clkPeriod   = 100;
    localparam int resetCycles = 5;
    localparam int numTicks    = 400;
    localparam int maxGap      = 4; // Most cycles from one tick to the next

    logic                Clk;
    logic                arstN;
    logic                frameTick;
    logic [15:0]         keycode;
    posT                 player;
    posT                 pixel;
    logic                attacked;
    logic                isAlive;
    logic                isObj;
    logic [romAddrW-1:0] romAddr;
    posT                 enemyPos;
    dirT                 facing;
    logic                attackReady;
    logic                possessed;

    // Reference model of the registered enemy state
    int mx;
    int my;
    int mFacing;
    int mStay;
    int mStep;
    bit mPoss;
    bit mReady;

    logic [31:0] lfsr;
    int          errorCount;

    enemySubsystem #(.spawnSlot(0)) DUT (
        .Clk         (Clk),
        .arstN       (arstN),
        .frameTick   (frameTick),
        .keycode     (keycode),
        .player      (player),
        .pixel       (pixel),
        .attacked    (attacked),
        .isAlive     (isAlive),
        .isObj       (isObj),
        .romAddr     (romAddr),
        .enemyPos    (enemyPos),
        .facing      (facing),
        .attackReady (attackReady),
        .possessed   (possessed)
    );

    always #(clkPeriod / 2) Clk = ~Clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrShift(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic int randBits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrShift(lfsr); // One shift per bit taken
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    task automatic expectEqual(input int actual, input int expected, input string what);
        if (actual != expected) begin
            errorCount++;
            $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, actual,
                     expected);
            $display("Simulation failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    function automatic bit keyPressed(input logic [15:0] code, input logic [7:0] key);
        return (code[7:0] == key) || (code[15:8] == key);
    endfunction

    // Mostly direction keys, G now and then, the rest are codes with no meaning here
    function automatic logic [7:0] pickKey();
        int c;
        logic [7:0] k;
        c = randBits(4);
        case (c)
            0, 1:    k = keyW;
            2, 3:    k = keyA;
            4, 5:    k = keyS;
            6, 7:    k = keyD;
            8:       k = keyG;
            default: k = 8'h30 + 8'(c);
        endcase
        return k;
    endfunction

    function automatic int reverseDir(input int d);
        int r;
        case (d)
            dirDown: r = dirUp;
            dirUp:   r = dirDown;
            dirLeft: r = dirRight;
            default: r = dirLeft;
        endcase
        return r;
    endfunction

    // One Clk edge of the model, with the inputs of the cycle before it
    task automatic modelClock(input bit tick, input bit hit, input bit alive,
                              input logic [15:0] code, input posT pl);
        int  plx;
        int  ply;
        int  dir;
        int  step;
        int  nx;
        int  ny;
        bit  want;
        bit  can;
        bit  taken;
        bit  stunned;
        bit  overlap;
        bit  goRight;
        bit  goLeft;
        bit  goDown;
        bit  goUp;
        plx = int'(pl.x);
        ply = int'(pl.y);
        if (!alive) begin
            mReady = 0;
        end
        if (tick) begin
            stunned = (mStay != 0);
            if (mPoss) begin
                goRight = keyPressed(code, keyD);
                goLeft  = keyPressed(code, keyA);
                goDown  = keyPressed(code, keyS);
                goUp    = keyPressed(code, keyW);
            end else begin
                goRight = (mx + spriteW < plx);
                goLeft  = (mx > plx + playerW);
                goDown  = (my + spriteH < ply);
                goUp    = (my > ply + playerH);
            end
            dir  = mFacing;
            step = walkStep;
            want = 1;
            if (hit) begin
                dir  = reverseDir(mFacing);
                step = knockStep;
            end else if (stunned) begin
                want = 0;
            end else if (goRight) begin
                dir = dirRight;
            end else if (goLeft) begin
                dir = dirLeft;
            end else if (goDown) begin
                dir = dirDown;
            end else if (goUp) begin
                dir = dirUp;
            end else begin
                want = 0;
            end
            nx = mx;
            ny = my;
            case (dir)
                dirRight: begin
                    can = (mx + spriteW + step <= xMax);
                    nx  = mx + step;
                end
                dirLeft: begin
                    can = (mx >= xMin + step);
                    nx  = mx - step;
                end
                dirDown: begin
                    can = (my + spriteH + step <= yMax);
                    ny  = my + step;
                end
                default: begin
                    can = (my >= yMin + step);
                    ny  = my - step;
                end
            endcase
            overlap = (mx + spriteW + attackDist >= plx) && (mx <= plx + playerW + attackDist)
                   && (my + spriteH + attackDist >= ply) && (my <= ply + playerH + attackDist);
            taken = want && can;
            if (alive) begin
                if (taken) begin
                    mx    = nx;
                    my    = ny;
                    mStep = (mStep + 1) % 4;
                end
                if (want && !hit) begin
                    mFacing = dir; // Turns even when the arena edge blocks the step
                end
                mReady = mPoss ? overlap : (!taken && !hit && !stunned);
            end
            if (hit) begin
                mStay = 1;
            end else if (mStay == stayFrames) begin
                mStay = 0;
            end else if (mStay != 0) begin
                mStay++;
            end
            if (keyPressed(code, keyG)) begin
                mPoss = !mPoss;
            end
        end
    endtask

    task automatic checkPixel(input posT pix, input bit alive);
        int dx;
        int dy;
        int pose;
        int addr;
        bit hitBox;
        dx     = int'(pix.x) - mx;
        dy     = int'(pix.y) - my;
        hitBox = alive && dx >= 0 && dx < spriteW && dy >= 0 && dy < spriteH;
        if (mStay != 0) begin
            pose = 3;
        end else begin
            pose = (mStep % 2 == 1) ? 1 + mStep / 2 : 0;
        end
        addr = (4 * mFacing + pose) * spriteW * spriteH + dy * spriteW + dx;
        expectEqual(isObj, hitBox, "isObj");
        expectEqual(romAddr, hitBox ? addr : 0, "romAddr");
    endtask

    task automatic checkState(input string phase);
        expectEqual(enemyPos.x, mx, {phase, " enemyPos.x"});
        expectEqual(enemyPos.y, my, {phase, " enemyPos.y"});
        expectEqual(int'(facing), mFacing, {phase, " facing"});
        expectEqual(attackReady, mReady, {phase, " attackReady"});
        expectEqual(possessed, mPoss, {phase, " possessed"});
    endtask

    // Starts and ends on a falling edge
    task automatic runCycle(input bit tick);
        posT         pl;
        posT         pix;
        bit          hit;
        bit          alive;
        logic [15:0] code;
        pl    = player;
        alive = isAlive;
        code  = keycode;
        hit   = 0;
        if (tick) begin
            code = {pickKey(), pickKey()};
            hit  = (randBits(4) == 0);
            alive = isAlive ? (randBits(5) != 0) : (randBits(2) == 0);
            if (randBits(3) == 0) begin
                if (randBits(1)) begin
                    pl.x = coordW'(mx + randBits(6) - 24); // Near the enemy
                    pl.y = coordW'(my + randBits(6) - 24);
                end else begin
                    pl.x = coordW'(randBits(9) % 302);
                    pl.y = coordW'(yMin + randBits(8) % 134);
                end
            end
        end
        if (randBits(2) != 0) begin
            pix.x = coordW'(mx + randBits(5) - 3);
            pix.y = coordW'(my + randBits(5) - 3);
        end else begin
            pix.x = coordW'(randBits(9));
            pix.y = coordW'(randBits(9));
        end
        frameTick = tick;
        attacked  = hit;
        isAlive   = alive;
        keycode   = code;
        player    = pl;
        pixel     = pix;
        #(clkPeriod / 10);
        checkPixel(pix, alive);
        modelClock(tick, hit, alive, code, pl);
        @(negedge Clk);
        checkState("cycle");
    endtask

    initial begin
        Clk        = 1'b0;
        arstN      = 1'b0;
        frameTick  = 1'b0;
        keycode    = '0;
        player     = '{x: 9'd150, y: 9'd120};
        pixel      = '0;
        attacked   = 1'b0;
        isAlive    = 1'b1;
        lfsr       = 32'd66642;
        errorCount = 0;
        // Spawn x of slot 0 wraps below zero in 9 bits
        mx      = (int'(spawnX[0]) - spriteW / 2) & 511;
        my      = (int'(spawnY[0]) - spriteH / 2) & 511;
        mFacing = dirDown;
        mStay   = 0;
        mStep   = 0;
        mPoss   = 0;
        mReady  = 0;
        repeat (resetCycles) @(posedge Clk);
        @(negedge Clk);
        arstN = 1'b1;
        checkState("reset");
        for (int t = 0; t < numTicks; t++) begin
            runCycle(1'b1);
            repeat (randBits(2)) runCycle(1'b0);
        end
        if (errorCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #((numTicks * maxGap + resetCycles + 10) * clkPeriod);
        $display("Timeout: the test did not finish in the expected time");
        $display("Simulation failed");
        $fatal(1, "Watchdog expired");
    end

endmodule
